/* common/ccx_pkg.sv */
// Shared definitions for the memory side of the core complex.
// Holds the address map, the timer register offsets and the
// request and response structs carried on every memory port.
// Every RTL module imports it in its header.

`default_nettype none

package ccx_pkg;

    // ----------------------------------------
    // Address map.
    // ----------------------------------------
    localparam logic [31:0] RAM_BASE  = 32'h0001_0000; // Local RAM window.
    localparam logic [31:0] RAM_SIZE  = 32'h0000_0400; // 1 KiB.
    localparam logic [31:0] MMIO_BASE = 32'h0002_0000; // Timer block window.
    localparam logic [31:0] MMIO_SIZE = 32'h0000_0100; // 256 bytes.
    localparam logic [31:0] EXT_BASE  = 32'h1000_0000; // External memory window.
    localparam logic [31:0] EXT_SIZE  = 32'h1000_0000; // 256 MiB.

    // RAM geometry derived from the window size.
    localparam int unsigned RAM_WORDS = RAM_SIZE / 4;        // Depth in words.
    localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);   // Word index width.

    // ----------------------------------------
    // Timer registers.
    // ----------------------------------------
    localparam logic [31:0] MTIME_LO_OFF    = 32'h0000_0000; // mtime[31:0].
    localparam logic [31:0] MTIME_HI_OFF    = 32'h0000_0004; // mtime[63:32].
    localparam logic [31:0] MTIMECMP_LO_OFF = 32'h0000_0008; // mtimecmp[31:0].
    localparam logic [31:0] MTIMECMP_HI_OFF = 32'h0000_000C; // mtimecmp[63:32].

    // Compare value out of reset, far enough out that no interrupt fires.
    localparam logic [63:0] MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

    // ----------------------------------------
    // Memory port structs.
    // ----------------------------------------
    typedef struct packed {
        logic        req;   // Start request.
        logic        wen;   // Write enable.
        logic [3:0]  strb;  // Byte write strobe.
        logic [31:0] wdata; // Write data.
        logic [31:0] addr;  // Byte address.
    } ccx_mem_req_t;

    // gnt is same-cycle; error and rdata land one cycle after the grant.
    typedef struct packed {
        logic        gnt;   // Request accepted.
        logic        error; // Access fault.
        logic [31:0] rdata; // Read data.
    } ccx_mem_rsp_t;

endpackage

`default_nettype wire

/* ccx_ram/ccx_ram.sv */
// Local RAM behind the bus router.
// Grants every request in the cycle it is raised, applies byte-strobed
// writes and returns read data from a register one cycle later.
// Contents are not cleared by reset.

`default_nettype none

module ccx_ram import ccx_pkg::*; (
    input  logic         f_clk,   // Free-running clock.
    input  logic         rst_n,   // Synchronous active low reset.
    input  ccx_mem_req_t ram_req, // Request steered by the router.
    output ccx_mem_rsp_t ram_rsp  // Grant and read response.
);

    logic [31:0]       mem [RAM_WORDS]; // Word storage.
    logic [RAM_AW-1:0] idx;             // Word index.
    logic [31:0]       rdata_q;         // Registered read word.

    assign idx = ram_req.addr[RAM_AW+1:2]; // Drop byte offset.

    // ----------------------------------------
    // Write path.
    // ----------------------------------------
    always_ff @(posedge f_clk) begin
        if (ram_req.req && ram_req.wen) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.strb[i]) begin
                    mem[idx][8*i +: 8] <= ram_req.wdata[8*i +: 8]; // Only strobed lanes.
                end
            end
        end
    end

    // ----------------------------------------
    // Read path.
    // ----------------------------------------
    always_ff @(posedge f_clk) begin
        if (ram_req.req && !ram_req.wen) begin
            rdata_q <= mem[idx]; // Valid the cycle after gnt.
        end
    end

    always_comb begin
        ram_rsp.gnt   = ram_req.req; // Never stalls.
        ram_rsp.error = 1'b0;        // No faults here.
        ram_rsp.rdata = rdata_q;
    end

    // The router must only steer RAM-window addresses here.
    a_ram_in_window: assert property (
        @(posedge f_clk) disable iff (!rst_n)
        ram_req.req |-> ((ram_req.addr - RAM_BASE) < RAM_SIZE)
    ) else $error("RAM request outside its window.");

endmodule

`default_nettype wire

/* ccx_mmio/ccx_mmio.sv */
// Memory-mapped timer block with mtime and mtimecmp.
// Both 64-bit registers are accessed as byte-strobed 32-bit halves.
// mtime counts every cycle; int_timer is a registered compare level.

`default_nettype none

module ccx_mmio import ccx_pkg::*; (
    input  logic         f_clk,     // Free-running clock.
    input  logic         rst_n,     // Synchronous active low reset.
    input  ccx_mem_req_t mmio_req,  // Request steered by the router.
    output ccx_mem_rsp_t mmio_rsp,  // Grant and read response.
    output logic         int_timer  // Timer interrupt level.
);

    logic [31:0] off;                        // Offset into the block.
    logic        sel_tl, sel_th;             // mtime halves hit.
    logic        sel_cl, sel_ch;             // mtimecmp halves hit.
    logic        off_ok;                     // One of the four registers.
    logic        wr, rd;                     // Qualified access strobes.
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] rd_mux;                     // Selected half.
    logic [31:0] rdata_q;
    logic        error_q;

    // Replace only the strobed bytes of a register half.
    function automatic logic [31:0] merge(input logic [31:0] old,
                                          input logic [31:0] wdata,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    // ----------------------------------------
    // Register decode.
    // ----------------------------------------
    assign off    = mmio_req.addr - MMIO_BASE;
    assign sel_tl = (off == MTIME_LO_OFF);
    assign sel_th = (off == MTIME_HI_OFF);
    assign sel_cl = (off == MTIMECMP_LO_OFF);
    assign sel_ch = (off == MTIMECMP_HI_OFF);
    assign off_ok = sel_tl | sel_th | sel_cl | sel_ch;
    assign wr     = mmio_req.req &  mmio_req.wen;
    assign rd     = mmio_req.req & ~mmio_req.wen;

    // ----------------------------------------
    // mtime and mtimecmp.
    // ----------------------------------------
    always_ff @(posedge f_clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr && sel_tl) begin
            mtime[31:0] <= merge(mtime[31:0], mmio_req.wdata, mmio_req.strb); // Count resumes next.
        end else if (wr && sel_th) begin
            mtime[63:32] <= merge(mtime[63:32], mmio_req.wdata, mmio_req.strb);
        end else begin
            mtime <= mtime + 64'd1; // Free-running.
        end
    end

    always_ff @(posedge f_clk) begin
        if (!rst_n) begin
            mtimecmp <= MTIMECMP_RESET;
        end else if (wr && sel_cl) begin
            mtimecmp[31:0] <= merge(mtimecmp[31:0], mmio_req.wdata, mmio_req.strb);
        end else if (wr && sel_ch) begin
            mtimecmp[63:32] <= merge(mtimecmp[63:32], mmio_req.wdata, mmio_req.strb);
        end
    end

    // ----------------------------------------
    // Read response.
    // ----------------------------------------
    always_comb begin
        rd_mux = '0; // Unknown offsets read as zero.
        if (sel_tl) rd_mux = mtime[31:0];
        if (sel_th) rd_mux = mtime[63:32];
        if (sel_cl) rd_mux = mtimecmp[31:0];
        if (sel_ch) rd_mux = mtimecmp[63:32];
    end

    always_ff @(posedge f_clk) begin
        if (rd) rdata_q <= rd_mux; // Half as seen at the grant.
    end

    always_ff @(posedge f_clk) begin
        if (!rst_n) begin
            error_q   <= 1'b0;
            int_timer <= 1'b0;
        end else begin
            if (mmio_req.req) error_q <= !off_ok; // Faults on reads and writes.
            int_timer <= (mtime >= mtimecmp);     // One cycle behind compare.
        end
    end

    always_comb begin
        mmio_rsp.gnt   = mmio_req.req; // Never stalls.
        mmio_rsp.error = error_q;
        mmio_rsp.rdata = rdata_q;
    end

    // A parked compare value keeps the interrupt quiet on the next cycle.
    a_no_irq_parked: assert property (
        @(posedge f_clk) disable iff (!rst_n)
        (mtimecmp == MTIMECMP_RESET && mtime != MTIMECMP_RESET) |=> !int_timer
    ) else $error("Timer interrupt raised with mtimecmp parked.");

endmodule

`default_nettype wire

/* design/ccx_bus_router.sv */
// Address decoder and response multiplexer for the single requester port.
// Steers each request to RAM, timer or external port, answers unmapped
// addresses with an error, and picks the granted region's response one
// cycle after the grant.

`default_nettype none

module ccx_bus_router import ccx_pkg::*; (
    input  logic         f_clk,    // Free-running clock.
    input  logic         rst_n,    // Synchronous active low reset.
    input  ccx_mem_req_t cpu_req,  // Requester side.
    output ccx_mem_rsp_t cpu_rsp,
    output ccx_mem_req_t ram_req,  // Local RAM.
    input  ccx_mem_rsp_t ram_rsp,
    output ccx_mem_req_t mmio_req, // Timer block.
    input  ccx_mem_rsp_t mmio_rsp,
    output ccx_mem_req_t ext_req,  // External memory port.
    input  ccx_mem_rsp_t ext_rsp
);

    logic       hit_ram;  // Address in RAM window.
    logic       hit_mmio; // Address in timer window.
    logic       hit_ext;  // Address in external window.
    logic       hit_none; // Unmapped hole.
    logic [3:0] hit_vec;  // {ext, mmio, ram, none}.
    logic [3:0] sel_q;    // Region granted last cycle.

    // ----------------------------------------
    // Address decode.
    // ----------------------------------------
    assign hit_ram  = (cpu_req.addr - RAM_BASE)  < RAM_SIZE;  // Wraps below base.
    assign hit_mmio = (cpu_req.addr - MMIO_BASE) < MMIO_SIZE;
    assign hit_ext  = (cpu_req.addr - EXT_BASE)  < EXT_SIZE;
    assign hit_none = !(hit_ram || hit_mmio || hit_ext);
    assign hit_vec  = {hit_ext, hit_mmio, hit_ram, hit_none};

    // ----------------------------------------
    // Request steering.
    // ----------------------------------------
    always_comb begin
        ram_req      = cpu_req;
        mmio_req     = cpu_req;
        ext_req      = cpu_req;
        ram_req.req  = cpu_req.req & hit_ram;  // Only the hit region sees req.
        mmio_req.req = cpu_req.req & hit_mmio;
        ext_req.req  = cpu_req.req & hit_ext;
    end

    // ----------------------------------------
    // Grant return and region tracking.
    // ----------------------------------------
    always_ff @(posedge f_clk) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (cpu_rsp.gnt) begin
            sel_q <= hit_vec; // Remember who owns next cycle's response.
        end else begin
            sel_q <= '0;
        end
    end

    always_comb begin
        // Grant path.
        if (hit_ram) begin
            cpu_rsp.gnt = ram_rsp.gnt;
        end else if (hit_mmio) begin
            cpu_rsp.gnt = mmio_rsp.gnt;
        end else if (hit_ext) begin
            cpu_rsp.gnt = ext_rsp.gnt; // Back-pressure from outside.
        end else begin
            cpu_rsp.gnt = cpu_req.req; // Hole grants at once.
        end

        // Response path, one cycle behind.
        cpu_rsp.error = 1'b0;
        cpu_rsp.rdata = '0;
        if (sel_q[1]) begin
            cpu_rsp.error = ram_rsp.error;
            cpu_rsp.rdata = ram_rsp.rdata;
        end else if (sel_q[2]) begin
            cpu_rsp.error = mmio_rsp.error;
            cpu_rsp.rdata = mmio_rsp.rdata;
        end else if (sel_q[3]) begin
            cpu_rsp.error = ext_rsp.error;
            cpu_rsp.rdata = ext_rsp.rdata;
        end else if (sel_q[0]) begin
            cpu_rsp.error = 1'b1; // Unmapped, rdata stays zero.
        end
    end

    // ----------------------------------------
    // Protocol checks.
    // ----------------------------------------
    a_one_region: assert property (
        @(posedge f_clk) disable iff (!rst_n)
        $onehot0({ram_req.req, mmio_req.req, ext_req.req})
    ) else $error("More than one region requested.");

    // Requester must hold the request until it is granted.
    a_req_stable: assert property (
        @(posedge f_clk) disable iff (!rst_n)
        (cpu_req.req && !cpu_rsp.gnt) |=> $stable(cpu_req)
    ) else $error("Request changed before grant.");

endmodule

`default_nettype wire

/* design/ccx_mem_top_v.sv */
// Top level of the memory side with plain ports only.
// Packs the flat wires onto request and response structs and wires
// the router to the local RAM, the timer block and the external port.

`default_nettype none

module ccx_mem_top_v import ccx_pkg::*; (
    input  logic        f_clk,         // Free-running clock.
    input  logic        rst_n,         // Synchronous active low reset.

    input  logic        cpu_req_valid, // Start memory request.
    input  logic        cpu_wen,       // Write enable.
    input  logic [3:0]  cpu_strb,      // Write strobe.
    input  logic [31:0] cpu_wdata,     // Write data.
    input  logic [31:0] cpu_addr,      // Byte address.
    output logic        cpu_gnt,       // Request accepted.
    output logic        cpu_error,     // Access fault.
    output logic [31:0] cpu_rdata,     // Read data.

    output logic        if_ext_req,    // External request.
    output logic        if_ext_wen,
    output logic [3:0]  if_ext_strb,
    output logic [31:0] if_ext_wdata,
    output logic [31:0] if_ext_addr,
    input  logic        if_ext_gnt,    // External grant.
    input  logic        if_ext_error,
    input  logic [31:0] if_ext_rdata,

    output logic        int_timer      // Timer interrupt level.
);

    ccx_mem_req_t cpu_req, ram_req, mmio_req, ext_req;
    ccx_mem_rsp_t cpu_rsp, ram_rsp, mmio_rsp, ext_rsp;

    // ----------------------------------------
    // Port packing.
    // ----------------------------------------
    always_comb begin
        cpu_req.req   = cpu_req_valid;
        cpu_req.wen   = cpu_wen;
        cpu_req.strb  = cpu_strb;
        cpu_req.wdata = cpu_wdata;
        cpu_req.addr  = cpu_addr;
        ext_rsp.gnt   = if_ext_gnt;   // From outside.
        ext_rsp.error = if_ext_error;
        ext_rsp.rdata = if_ext_rdata;
    end

    assign cpu_gnt      = cpu_rsp.gnt;
    assign cpu_error    = cpu_rsp.error;
    assign cpu_rdata    = cpu_rsp.rdata;
    assign if_ext_req   = ext_req.req;
    assign if_ext_wen   = ext_req.wen;
    assign if_ext_strb  = ext_req.strb;
    assign if_ext_wdata = ext_req.wdata;
    assign if_ext_addr  = ext_req.addr;

    // ----------------------------------------
    // Instances.
    // ----------------------------------------
    ccx_bus_router i_router (
        .f_clk    (f_clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .ext_req  (ext_req),
        .ext_rsp  (ext_rsp)
    );

    ccx_ram i_ram (
        .f_clk   (f_clk),
        .rst_n   (rst_n),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

    ccx_mmio i_mmio (
        .f_clk     (f_clk),
        .rst_n     (rst_n),
        .mmio_req  (mmio_req),
        .mmio_rsp  (mmio_rsp),
        .int_timer (int_timer)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Clock and reset source for the memory-side testbench.
// 8 ns clock, rst_n held low over the first 4 rising edges.

`default_nettype none

module tb_clock_gen (
    output logic f_clk, // 125 MHz clock.
    output logic rst_n  // Synchronous active low reset.
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        f_clk = 1'b0;
        forever #4 f_clk = ~f_clk; // Half period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge f_clk); // Four reset cycles.
        @(negedge f_clk);
        rst_n = 1'b1; // Released away from the active edge.
    end

endmodule

`default_nettype wire

/* verification/tb_ccx_mem.sv */
// Testbench for the memory-side top level.
// Drives the flat requester port on falling edges, models the external
// memory with a random grant delay, and checks RAM, external, unmapped
// and timer accesses against reference functions.

`default_nettype none

module tb_ccx_mem import ccx_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] MTIME_LO_ADDR    = 32'h0002_0000; // Absolute timer map.
    localparam logic [31:0] MTIMECMP_LO_ADDR = 32'h0002_0008;
    localparam logic [31:0] MTIMECMP_HI_ADDR = 32'h0002_000C;
    localparam logic [31:0] EXT_XOR          = 32'hA5A5_5A5A; // External read pattern.
    localparam int          GNT_TIMEOUT      = 20;            // Cycles per grant wait.
    localparam logic [31:0] HOLE_ADDR [4] = '{32'h0003_0000, 32'h0000_0000,
                                              32'h0001_0400, 32'h2000_0000};

    logic        f_clk, rst_n;
    logic        cpu_req_valid, cpu_wen, cpu_gnt, cpu_error;
    logic [3:0]  cpu_strb;
    logic [31:0] cpu_wdata, cpu_addr, cpu_rdata;
    logic        if_ext_req, if_ext_wen, if_ext_gnt, if_ext_error;
    logic [3:0]  if_ext_strb;
    logic [31:0] if_ext_wdata, if_ext_addr, if_ext_rdata;
    logic        int_timer;

    int          seed = 32'h6a2d;          // Single random stream.
    logic [1:0]  ext_delay [32];           // Grant delays, drawn at start.
    logic        ext_busy;                 // Request seen, grant pending.
    logic [1:0]  ext_wait;                 // Cycles left before grant.
    int          ext_grants, ext_req_cycles;
    logic [31:0] ext_last_addr, ext_last_wdata;
    logic [3:0]  ext_last_strb;
    logic        ext_last_wen;             // Direction of the last grant.
    string       name_q [$];               // Pending checks.
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    int          n_checks, n_mismatch, n_timeouts;

    tb_clock_gen clock_gen (.f_clk(f_clk), .rst_n(rst_n));

    ccx_mem_top_v DUT (
        .f_clk(f_clk), .rst_n(rst_n),
        .cpu_req_valid(cpu_req_valid), .cpu_wen(cpu_wen), .cpu_strb(cpu_strb),
        .cpu_wdata(cpu_wdata), .cpu_addr(cpu_addr),
        .cpu_gnt(cpu_gnt), .cpu_error(cpu_error), .cpu_rdata(cpu_rdata),
        .if_ext_req(if_ext_req), .if_ext_wen(if_ext_wen), .if_ext_strb(if_ext_strb),
        .if_ext_wdata(if_ext_wdata), .if_ext_addr(if_ext_addr),
        .if_ext_gnt(if_ext_gnt), .if_ext_error(if_ext_error), .if_ext_rdata(if_ext_rdata),
        .int_timer(int_timer)
    );

    // ----------------------------------------
    // Reference model.
    // ----------------------------------------
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}}; // Lane mask.
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] size);
        return (addr >= base) && (addr <= base + (size - 32'd1));
    endfunction

    function automatic logic expected_error(input logic [31:0] addr);
        return !(in_window(addr, RAM_BASE, RAM_SIZE) || in_window(addr, MMIO_BASE, MMIO_SIZE)
                 || in_window(addr, EXT_BASE, EXT_SIZE)); // Only the hole faults.
    endfunction

    function automatic logic [31:0] ext_read_data(input logic [31:0] addr);
        return addr ^ EXT_XOR;
    endfunction

    function automatic void post_check(input string name, input logic [31:0] exp_v,
                                       input logic [31:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endfunction

    // ----------------------------------------
    // External memory and compare process.
    // ----------------------------------------
    initial begin : ext_memory
        if_ext_gnt     = 1'b0;
        if_ext_error   = 1'b0;
        if_ext_rdata   = '0;
        ext_busy       = 1'b0;
        ext_wait       = '0;
        ext_grants     = 0;
        ext_req_cycles = 0;
        forever begin
            @(posedge f_clk); // Sample the held request.
            if (if_ext_req) ext_req_cycles++;
            if (if_ext_req && if_ext_gnt) begin
                ext_busy      = 1'b0; // Granted at this edge.
                ext_grants++;
                ext_last_addr = if_ext_addr;
                ext_last_wen  = if_ext_wen;
                if (if_ext_wen) begin
                    ext_last_wdata = if_ext_wdata;
                    ext_last_strb  = if_ext_strb;
                end
            end else if (if_ext_req && !ext_busy) begin
                ext_busy = 1'b1;
                ext_wait = ext_delay[ext_grants % 32];
            end else if (ext_busy && ext_wait != 2'd0) begin
                ext_wait = ext_wait - 2'd1;
            end
            @(negedge f_clk);
            if (ext_busy && ext_wait == 2'd0) begin
                if_ext_gnt   = 1'b1;
                if_ext_error = 1'b0;
                if_ext_rdata = ext_read_data(if_ext_addr); // Held through the response cycle.
            end else begin
                if_ext_gnt   = 1'b0;
            end
        end
    end

    initial begin : compare
        string       name;
        logic [31:0] exp_v, act_v;
        n_checks   = 0;
        n_mismatch = 0;
        forever begin
            @(posedge f_clk);
            while (name_q.size() != 0) begin
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                n_checks++;
                assert (act_v === exp_v) else begin
                    n_mismatch++;
                    $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
                end
            end
        end
    end

    // ----------------------------------------
    // Requester.
    // ----------------------------------------
    task automatic issue_access(input string name, input logic wen, input logic [3:0] strb,
                                input logic [31:0] wdata, input logic [31:0] addr,
                                output logic [31:0] rdata, output logic error);
        int   cycles;
        logic granted;
        cycles  = 0;
        granted = 1'b0;
        @(negedge f_clk);
        cpu_req_valid = 1'b1;
        cpu_wen       = wen;
        cpu_strb      = strb;
        cpu_wdata     = wdata;
        cpu_addr      = addr;
        while (!granted && cycles < GNT_TIMEOUT) begin
            @(posedge f_clk);
            cycles++;
            granted = cpu_gnt;
            if (in_window(addr, EXT_BASE, EXT_SIZE)) begin // Back-pressure passes through.
                post_check({name, "_gnt_follows_ext"}, 32'(if_ext_gnt), 32'(cpu_gnt));
            end
        end
        if (!granted) begin
            $display("ERROR: %s was not granted within %0d cycles", name, GNT_TIMEOUT);
            n_timeouts++;
        end
        @(negedge f_clk); // Response cycle.
        rdata         = cpu_rdata;
        error         = cpu_error;
        cpu_req_valid = 1'b0;
    endtask

    task automatic check_idle(input string prefix);
        post_check({prefix, "_cpu_gnt"}, 32'd0, 32'(cpu_gnt));
        post_check({prefix, "_ext_req"}, 32'd0, 32'(if_ext_req));
        post_check({prefix, "_int_timer"}, 32'd0, 32'(int_timer));
    endtask

    initial begin : stimulus
        logic [31:0] ram_addr [16];
        logic [31:0] shadow [16];
        logic [31:0] rd, wd, addr, t1, t2;
        logic [3:0]  st;
        logic        err;
        int          r, k, cycles, ext_before;
        cpu_req_valid = 1'b0;
        cpu_wen       = 1'b0;
        cpu_strb      = '0;
        cpu_wdata     = '0;
        cpu_addr      = '0;
        n_timeouts    = 0;
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            ext_delay[i] = r[1:0]; // 0 to 3 extra cycles.
        end

        // Reset.
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(negedge f_clk);
            cycles++;
            check_idle("reset");
        end
        if (rst_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            n_timeouts++;
        end
        @(negedge f_clk);
        check_idle("after_reset");

        // RAM: full writes, strobed writes, then reads.
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            ram_addr[i] = RAM_BASE + {22'd0, 4'(i), r[3:0], 2'b00}; // Distinct words.
            shadow[i]   = $random(seed);
            issue_access("ram_init", 1'b1, 4'hF, shadow[i], ram_addr[i], rd, err);
        end
        for (int n = 0; n < 24; n++) begin
            r  = $random(seed);
            k  = r & 15;
            st = r[7:4];
            wd = $random(seed);
            shadow[k] = merge_bytes(shadow[k], wd, st);
            issue_access("ram_strb_write", 1'b1, st, wd, ram_addr[k], rd, err);
            post_check("ram_write_error", 32'(expected_error(ram_addr[k])), 32'(err));
        end
        for (int i = 0; i < 16; i++) begin
            issue_access("ram_read", 1'b0, 4'h0, 32'd0, ram_addr[i], rd, err);
            post_check("ram_read_data", shadow[i], rd);
            post_check("ram_read_error", 32'(expected_error(ram_addr[i])), 32'(err));
        end

        // External region, writes and reads alternating.
        for (int n = 0; n < 8; n++) begin
            r    = $random(seed);
            addr = EXT_BASE + {4'd0, r[27:2], 2'b00};
            wd   = $random(seed);
            st   = r[31:28];
            if (n % 2 == 0) begin
                issue_access("ext_write", 1'b1, st, wd, addr, rd, err);
                post_check("ext_write_addr", addr, ext_last_addr);
                post_check("ext_write_wen", 32'd1, 32'(ext_last_wen));
                post_check("ext_write_data", wd, ext_last_wdata);
                post_check("ext_write_strb", 32'(st), 32'(ext_last_strb));
            end else begin
                issue_access("ext_read", 1'b0, 4'h0, 32'd0, addr, rd, err);
                post_check("ext_read_addr", addr, ext_last_addr);
                post_check("ext_read_wen", 32'd0, 32'(ext_last_wen));
                post_check("ext_read_data", ext_read_data(addr), rd);
            end
            post_check("ext_error", 32'(expected_error(addr)), 32'(err));
        end

        // Unmapped hole.
        ext_before = ext_req_cycles;
        for (int n = 0; n < 4; n++) begin
            issue_access("unmapped", (n == 1), 4'hF, 32'hDEAD_BEEF, HOLE_ADDR[n], rd, err);
            post_check("unmapped_error", 32'(expected_error(HOLE_ADDR[n])), 32'(err));
            post_check("unmapped_rdata", 32'd0, rd);
        end
        post_check("unmapped_ext_req", ext_before, ext_req_cycles);

        // Timer.
        issue_access("mtimecmp_write", 1'b1, 4'hF, 32'h1234_5678, MTIMECMP_LO_ADDR, rd, err);
        issue_access("mtimecmp_lo_read", 1'b0, 4'h0, 32'd0, MTIMECMP_LO_ADDR, rd, err);
        post_check("mtimecmp_lo_read", 32'h1234_5678, rd);
        issue_access("mtimecmp_hi_read", 1'b0, 4'h0, 32'd0, MTIMECMP_HI_ADDR, rd, err);
        post_check("mtimecmp_hi_read", 32'hFFFF_FFFF, rd);
        issue_access("mtimecmp_strb", 1'b1, 4'b0101, 32'hAABB_CCDD, MTIMECMP_LO_ADDR, rd, err);
        issue_access("mtimecmp_strb_read", 1'b0, 4'h0, 32'd0, MTIMECMP_LO_ADDR, rd, err);
        post_check("mtimecmp_strb_read",
                   merge_bytes(32'h1234_5678, 32'hAABB_CCDD, 4'b0101), rd);
        issue_access("mtime_read_1", 1'b0, 4'h0, 32'd0, MTIME_LO_ADDR, t1, err);
        issue_access("mtime_read_2", 1'b0, 4'h0, 32'd0, MTIME_LO_ADDR, t2, err);
        post_check("mtime_increasing", 32'd1, 32'(t2 > t1));
        issue_access("mtimecmp_arm_lo", 1'b1, 4'hF, t2 + 32'd20, MTIMECMP_LO_ADDR, rd, err);
        post_check("timer_before_arm", 32'd0, 32'(int_timer)); // High half still all ones.
        issue_access("mtimecmp_arm_hi", 1'b1, 4'hF, 32'd0, MTIMECMP_HI_ADDR, rd, err);
        cycles = 0;
        while (int_timer !== 1'b1 && cycles < 100) begin
            @(negedge f_clk);
            cycles++;
        end
        post_check("timer_irq_rise", 32'd1, 32'(int_timer));
        issue_access("mtimecmp_park_lo", 1'b1, 4'hF, 32'hFFFF_FFFF, MTIMECMP_LO_ADDR, rd, err);
        issue_access("mtimecmp_park_hi", 1'b1, 4'hF, 32'hFFFF_FFFF, MTIMECMP_HI_ADDR, rd, err);
        cycles = 0;
        while (int_timer !== 1'b0 && cycles < 10) begin
            @(negedge f_clk);
            cycles++;
        end
        post_check("timer_irq_fall", 32'd0, 32'(int_timer));

        // Let the compare process drain.
        cycles = 0;
        while (name_q.size() != 0 && cycles < 10) begin
            @(negedge f_clk);
            cycles++;
        end
        if (name_q.size() != 0) begin
            $display("ERROR: %0d checks were never compared", name_q.size());
            n_timeouts++;
        end
        $display("checks=%0d mismatches=%0d timeouts=%0d", n_checks, n_mismatch, n_timeouts);
        if (n_mismatch == 0 && n_timeouts == 0 && n_checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/ccx_pkg.sv
ccx_ram/ccx_ram.sv
ccx_mmio/ccx_mmio.sv
design/ccx_bus_router.sv
design/ccx_mem_top_v.sv
verification/tb_clock_gen.sv
verification/tb_ccx_mem.sv

/* Makefile */
# Verilator build, run and lint for the memory-side testbench.
VERILATOR := verilator
TOP       := tb_ccx_mem
FILELIST  := all.f
OBJ_DIR   := obj_dir
COMMON    := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
VFLAGS    := --binary $(COMMON) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only $(COMMON)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Pass only when the testbench prints its pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
